//--- Makefile
# Verilator build and run of the bf16 FPU testbench

OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_fpu with Verilator, run it, check sim.log"
	@echo "  clean  remove $(OBJ) and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_fpu -f vlog.f -Mdir $(OBJ) -o tb_fpu
	./$(OBJ)/tb_fpu > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "^sim passed$$" sim.log

clean:
	rm -rf $(OBJ) sim.log

//--- bench/bf16_ref.svh
`ifndef bf16_ref_svh
`define bf16_ref_svh

// reference results for the fpu commands
// truncation toward zero, underflow to +0, overflow to signed infinity

// e is the biased exponent before range checks
function automatic bf16_t pack_result(input logic sign, input int e, input logic [6:0] man);
	bf16_t r;
	if (e <= 0)
		r = '0;
	else if (e >= 255)
		r = {sign, 8'hff, 7'h00};
	else
		r = {sign, 8'(e), man};
	return r;
endfunction

// exact sum in a wide fixed point, then truncated
function automatic bf16_t model_add(input bf16_t x, input bf16_t y);
	bf16_t big;
	bf16_t sml;
	logic [63:0] mb;
	logic [63:0] ms;
	logic [63:0] full;
	logic [63:0] r;
	int d;
	int p;
	// subnormals count as zero
	if (x.exp == 0 && y.exp == 0)
		return '0;
	if (x.exp == 0)
		return y;
	if (y.exp == 0)
		return x;
	if ({x.exp, x.man} >= {y.exp, y.man})
	begin
		big = x;
		sml = y;
	end
	else
	begin
		big = y;
		sml = x;
	end
	d = int'(big.exp) - int'(sml.exp);
	// hidden bit of the larger operand sits at bit 55
	mb = 64'({1'b1, big.man}) << 48;
	full = 64'({1'b1, sml.man}) << 48;
	if (d >= 56)
		ms = 64'd1;
	else
	begin
		ms = full >> d;
		// anything shifted out stays as a sticky lsb
		if ((ms << d) != full)
			ms[0] = 1'b1;
	end
	r = (big.sign == sml.sign) ? mb + ms : mb - ms;
	// exact cancellation
	if (r == 0)
		return '0;
	p = 63;
	while (!r[p])
		p--;
	return pack_result(big.sign, int'(big.exp) + p - 55, 7'((r << (63 - p)) >> 56));
endfunction

// product of the 8-bit significands, value in [1, 4)
function automatic bf16_t model_mul(input bf16_t x, input bf16_t y);
	logic [15:0] prod;
	logic [6:0] man;
	int e;
	if (x.exp == 0 || y.exp == 0)
		return '0;
	prod = 16'({1'b1, x.man}) * 16'({1'b1, y.man});
	e = int'(x.exp) + int'(y.exp) - bf16_exp_bias;
	if (prod[15])
	begin
		man = prod[14:8];
		e = e + 1;
	end
	else
		man = prod[13:7];
	return pack_result(x.sign ^ y.sign, e, man);
endfunction

// signed keys, both zeros and subnormals map to 0
function automatic bf16_t model_slt(input bf16_t x, input bf16_t y);
	int kx;
	int ky;
	kx = (x.exp == 0) ? 0 : int'({x.exp, x.man});
	ky = (y.exp == 0) ? 0 : int'({y.exp, y.man});
	if (x.sign)
		kx = -kx;
	if (y.sign)
		ky = -ky;
	return (kx < ky) ? bf16_one : bf16_t'(16'h0000);
endfunction

`endif

//--- bench/tb_fpu.sv
module tb_fpu;
	timeunit 1ns;
	timeprecision 100ps;
	import bf16_pkg::*;

	`include "bf16_ref.svh"

	// command counts also size the watchdog
	localparam int n_rand = 100;
	localparam int n_slt_rand = 60;
	localparam int n_mix = 24;
	localparam int n_directed = 14;
	localparam int n_cmds = 3 * n_rand + n_slt_rand + n_mix + n_directed;
	localparam int cycle_limit = 5 * n_cmds + 200;

	logic clk;
	logic arst_n;
	fpu_op_e op;
	bf16_t a;
	bf16_t b;
	logic start;
	logic ready;
	logic valid;
	bf16_t result;

	logic [31:0] lcg_state;
	int cycle_count;

	bf16_fpu DUT (
		.clk(clk),
		.arst_n(arst_n),
		.op(op),
		.a(a),
		.b(b),
		.start(start),
		.ready(ready),
		.valid(valid),
		.result(result)
	);

	// 4 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// watchdog
	initial
	begin
		cycle_count = 0;
		while (cycle_count < cycle_limit)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the DUT never finished", cycle_count);
		$display("sim failed");
		$fatal(1);
	end

	function logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// normal operand with its exponent in [lo, hi]
	function bf16_t rand_operand(input int lo, input int hi);
		logic [31:0] r;
		bf16_t v;
		r = lcg_next();
		v.sign = r[31];
		v.man = r[30:24];
		v.exp = 8'(lo + int'(r[23:8]) % (hi - lo + 1));
		return v;
	endfunction

	function automatic bf16_t flip_sign(input bf16_t v);
		bf16_t r;
		r = v;
		r.sign = ~v.sign;
		return r;
	endfunction

	task automatic check_equal(input string what, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want)
		begin
			$display("Error: %0.1f ns: %s: got %0h, expected %0h", $realtime, what, got, want);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	// drive point just after the next rising edge
	task automatic step_cycle();
		@(posedge clk);
		#0.5;
	endtask

	// issue one command and check result, latency and pulse width
	task automatic run_cmd(input fpu_op_e c_op, input bf16_t x, input bf16_t y,
		input bf16_t want, input int latency);
		int cycles;
		while (!ready)
			step_cycle();
		op = c_op;
		a = x;
		b = y;
		start = 1'b1;
		step_cycle();
		start = 1'b0;
		check_equal("ready after accept", ready, 0);
		cycles = 1;
		while (!valid)
		begin
			step_cycle();
			cycles++;
		end
		check_equal($sformatf("%s %h %h", c_op.name(), x, y), result, want);
		check_equal($sformatf("%s latency", c_op.name()), cycles, latency);
		// pulse lasts one cycle and ready returns right after
		step_cycle();
		check_equal("valid after pulse", valid, 0);
		check_equal("ready after pulse", ready, 1);
	endtask

	task automatic test_add();
		bf16_t x;
		bf16_t y;
		check_equal("ready after reset", ready, 1);
		check_equal("valid after reset", valid, 0);
		check_equal("result after reset", result, 0);
		for (int i = 0; i < n_rand; i++)
		begin
			x = rand_operand(110, 140);
			y = rand_operand(110, 140);
			run_cmd(op_add, x, y, model_add(x, y), 3);
		end
	endtask

	task automatic test_sub();
		bf16_t x;
		bf16_t y;
		for (int i = 0; i < n_rand; i++)
		begin
			x = rand_operand(110, 140);
			y = rand_operand(110, 140);
			run_cmd(op_sub, x, y, model_add(x, flip_sign(y)), 3);
		end
		// x - x is +0 whatever the sign
		run_cmd(op_sub, 16'h4049, 16'h4049, 16'h0000, 3);
		run_cmd(op_sub, 16'hc2f7, 16'hc2f7, 16'h0000, 3);
	endtask

	task automatic test_mul();
		bf16_t x;
		bf16_t y;
		for (int i = 0; i < n_rand; i++)
		begin
			x = rand_operand(80, 170);
			y = rand_operand(80, 170);
			run_cmd(op_mul, x, y, model_mul(x, y), 2);
		end
		// exponent 192 twice overflows
		run_cmd(op_mul, 16'h6000, 16'h6000, 16'h7f80, 2);
		run_cmd(op_mul, 16'he000, 16'h6000, 16'hff80, 2);
		// exponent 20 twice underflows even with a negative operand
		run_cmd(op_mul, 16'h8a00, 16'h0a00, 16'h0000, 2);
		// subnormal times 1.0
		run_cmd(op_mul, 16'h0040, 16'h3f80, 16'h0000, 2);
	endtask

	task automatic test_slt();
		bf16_t x;
		bf16_t y;
		for (int i = 0; i < n_slt_rand; i++)
		begin
			x = rand_operand(124, 130);
			y = rand_operand(124, 130);
			// some equal pairs and some opposite pairs
			if (i % 8 == 0)
				y = x;
			else if (i % 8 == 1)
				y = flip_sign(x);
			run_cmd(op_slt, x, y, model_slt(x, y), 1);
		end
		run_cmd(op_slt, 16'h8000, 16'h0000, 16'h0000, 1);
		run_cmd(op_slt, 16'h0000, 16'h8000, 16'h0000, 1);
		run_cmd(op_slt, 16'hbf80, 16'h3f80, 16'h3f80, 1);
		run_cmd(op_slt, 16'h3f80, 16'hbf80, 16'h0000, 1);
		run_cmd(op_slt, 16'h4040, 16'h4040, 16'h0000, 1);
		run_cmd(op_slt, 16'hc000, 16'hbf80, 16'h3f80, 1);
	endtask

	// a mul strobed into a busy add must be dropped
	task automatic test_busy_start();
		bf16_t x;
		bf16_t y;
		bf16_t want;
		int cycles;
		x = rand_operand(110, 140);
		y = rand_operand(110, 140);
		want = model_add(x, y);
		while (!ready)
			step_cycle();
		op = op_add;
		a = x;
		b = y;
		start = 1'b1;
		step_cycle();
		op = op_mul;
		a = y;
		b = x;
		cycles = 1;
		while (!valid)
		begin
			check_equal("ready while busy", ready, 0);
			step_cycle();
			cycles++;
		end
		// strobe stayed high through every busy edge
		start = 1'b0;
		check_equal("add result under ignored start", result, want);
		check_equal("add latency under ignored start", cycles, 3);
		repeat (6)
		begin
			step_cycle();
			check_equal("extra valid", valid, 0);
		end
		check_equal("ready after ignored start", ready, 1);
	endtask

	task automatic test_back_to_back();
		bf16_t x;
		bf16_t y;
		bf16_t want;
		fpu_op_e c_op;
		logic [31:0] r;
		int lat;
		for (int i = 0; i < n_mix; i++)
		begin
			x = rand_operand(110, 140);
			y = rand_operand(110, 140);
			r = lcg_next();
			c_op = fpu_op_e'(r[31:30]);
			case (c_op)
			op_add:
			begin
				want = model_add(x, y);
				lat = 3;
			end
			op_sub:
			begin
				want = model_add(x, flip_sign(y));
				lat = 3;
			end
			op_mul:
			begin
				want = model_mul(x, y);
				lat = 2;
			end
			default:
			begin
				want = model_slt(x, y);
				lat = 1;
			end
			endcase
			// issued in the first cycle ready is back
			run_cmd(c_op, x, y, want, lat);
		end
	endtask

	initial
	begin
		lcg_state = 32'h10375eb8;
		arst_n = 1'b0;
		start = 1'b0;
		op = op_add;
		a = '0;
		b = '0;
		repeat (4)
			@(posedge clk);
		#0.5;
		arst_n = 1'b1;
		test_add();
		test_sub();
		test_mul();
		test_slt();
		test_busy_start();
		test_back_to_back();
		$display("sim passed");
		$finish;
	end

endmodule

//--- hw/bf16_add.sv
module bf16_add (
	input logic clk,
	input logic arst_n,
	bf16_unit_if.unit u
);
	import bf16_pkg::*;

	// state tells which stage registers hold live data
	typedef enum logic [1:0] {
		st_idle,
		st_align,
		st_norm,
		st_pack
	} state_e;

	state_e state;
	logic accept;

	// stage one, combinational from the command
	logic [10:0] sig_a;
	logic [10:0] sig_b;
	logic a_big;
	logic [10:0] big_sig;
	logic [10:0] sml_sig;
	logic [7:0] big_exp;
	logic big_sign;
	logic [7:0] exp_diff;
	logic [3:0] shamt;
	logic [21:0] shifted;
	logic [10:0] sml_al;
	logic [11:0] sum;

	// aligned sum
	logic [11:0] s1_sum;
	logic [7:0] s1_exp;
	logic s1_sign;

	// normalized sum
	logic [3:0] lzc;
	logic [11:0] s2_sig;
	logic signed [9:0] s2_exp;
	logic s2_sign;
	logic s2_zero;

	assign accept = u.start && u.ready;

	always_comb
	begin
		// subnormals read as zero
		// three extra bits below the mantissa: guard, round, sticky
		sig_a = (u.a.exp == '0) ? '0 : {1'b1, u.a.man, 3'b000};
		sig_b = (u.b.exp == '0) ? '0 : {1'b1, u.b.man, 3'b000};
		// order by magnitude
		a_big = {u.a.exp, sig_a} >= {u.b.exp, sig_b};
		big_sig = a_big ? sig_a : sig_b;
		sml_sig = a_big ? sig_b : sig_a;
		big_exp = a_big ? u.a.exp : u.b.exp;
		big_sign = a_big ? u.a.sign : u.b.sign;
		exp_diff = a_big ? (u.a.exp - u.b.exp) : (u.b.exp - u.a.exp);
		// past 11 places the small operand is all sticky
		shamt = (exp_diff > 8'd11) ? 4'd11 : exp_diff[3:0];
		shifted = {sml_sig, 11'b0} >> shamt;
		// lost bits fold into the lsb
		sml_al = shifted[21:11] | {10'b0, |shifted[10:0]};
		// effective subtract on differing signs
		if (u.a.sign ^ u.b.sign)
			sum = {1'b0, big_sig} - {1'b0, sml_al};
		else
			sum = {1'b0, big_sig} + {1'b0, sml_al};
	end

	// leading zero count over the 12-bit sum, 12 when empty
	always_comb
	begin
		lzc = 4'd12;
		for (int i = 0; i < 12; i++)
		begin
			if (s1_sum[i])
				lzc = 4'(11 - i);
		end
	end

	// datapath registers
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			s1_sum <= sum;
			s1_exp <= big_exp;
			s1_sign <= big_sign;
		end
		if (state == st_align)
		begin
			// hidden bit ends up at bit 11
			s2_sig <= s1_sum << lzc;
			// carry out moves the exponent up by one
			s2_exp <= 10'(s1_exp) + 10'sd1 - 10'(lzc);
			s2_sign <= s1_sign;
			s2_zero <= (s1_sum == '0);
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= st_idle;
			u.ready <= 1'b1;
			u.valid <= 1'b0;
			u.data <= '0;
		end
		else
		begin
			case (state)
			st_idle:
			begin
				if (accept)
				begin
					state <= st_align;
					u.ready <= 1'b0;
				end
			end
			st_align:
			begin
				state <= st_norm;
			end
			st_norm:
			begin
				// truncate, flush, saturate
				u.data <= bf16_pack(s2_sign, s2_exp, s2_sig[10:4], s2_zero);
				u.valid <= 1'b1;
				state <= st_pack;
			end
			st_pack:
			begin
				// result on the bus for this one cycle
				u.valid <= 1'b0;
				u.ready <= 1'b1;
				state <= st_idle;
			end
			default:
			begin
				state <= st_idle;
			end
			endcase
		end
	end

endmodule

//--- hw/bf16_fpu.sv
module bf16_fpu (
	input logic clk,
	input logic arst_n,
	input bf16_pkg::fpu_op_e op,
	input bf16_pkg::bf16_t a,
	input bf16_pkg::bf16_t b,
	input logic start,
	output logic ready,
	output logic valid,
	output bf16_pkg::bf16_t result
);
	import bf16_pkg::*;

	// one bundle per execution unit
	bf16_unit_if add_if ();
	bf16_unit_if mul_if ();
	bf16_unit_if slt_if ();

	// opcode of the command in flight
	fpu_op_e pend_op;
	logic accept;
	bf16_t b_neg;
	logic sel_valid;
	bf16_t sel_data;

	// all units idle
	assign ready = add_if.ready && mul_if.ready && slt_if.ready;
	assign accept = start && ready;

	// sub runs through the adder with b flipped
	assign b_neg = {~b.sign, b.exp, b.man};

	// only the addressed unit sees the strobe
	assign add_if.start = accept && (op == op_add || op == op_sub);
	assign mul_if.start = accept && (op == op_mul);
	assign slt_if.start = accept && (op == op_slt);

	assign add_if.a = a;
	assign add_if.b = (op == op_sub) ? b_neg : b;
	assign mul_if.a = a;
	assign mul_if.b = b;
	assign slt_if.a = a;
	assign slt_if.b = b;

	bf16_add u_add (
		.clk(clk),
		.arst_n(arst_n),
		.u(add_if)
	);

	bf16_mul u_mul (
		.clk(clk),
		.arst_n(arst_n),
		.u(mul_if)
	);

	bf16_slt u_slt (
		.clk(clk),
		.arst_n(arst_n),
		.u(slt_if)
	);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			pend_op <= op_add;
		else if (accept)
			pend_op <= op;
	end

	// result path picked by the pending opcode
	always_comb
	begin
		case (pend_op)
		op_add, op_sub:
		begin
			sel_valid = add_if.valid;
			sel_data = add_if.data;
		end
		op_mul:
		begin
			sel_valid = mul_if.valid;
			sel_data = mul_if.data;
		end
		op_slt:
		begin
			sel_valid = slt_if.valid;
			sel_data = slt_if.data;
		end
		default:
		begin
			sel_valid = 1'b0;
			sel_data = '0;
		end
		endcase
		valid = sel_valid;
		// zero outside the valid pulse
		result = sel_valid ? sel_data : bf16_t'(0);
	end

endmodule

//--- hw/bf16_mul.sv
module bf16_mul (
	input logic clk,
	input logic arst_n,
	bf16_unit_if.unit u
);
	import bf16_pkg::*;

	logic accept;
	// stage one holds a product
	logic busy;

	// stage one, combinational from the command
	logic [15:0] prod;
	logic signed [9:0] p_exp;

	// stage one registers
	logic [15:0] s1_prod;
	logic signed [9:0] s1_exp;
	logic s1_sign;
	logic s1_zero;

	// stage two, combinational
	logic [6:0] n_man;
	logic signed [9:0] n_exp;

	assign accept = u.start && u.ready;

	always_comb
	begin
		// 8x8 significands, product in [1, 4)
		prod = {1'b1, u.a.man} * {1'b1, u.b.man};
		// biased sum, may leave the 8-bit range
		p_exp = 10'(u.a.exp) + 10'(u.b.exp) - 10'(bf16_exp_bias);
	end

	always_comb
	begin
		// product of two or more, one step right
		if (s1_prod[15])
		begin
			n_man = s1_prod[14:8];
			n_exp = s1_exp + 10'sd1;
		end
		else
		begin
			n_man = s1_prod[13:7];
			n_exp = s1_exp;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			s1_prod <= prod;
			s1_exp <= p_exp;
			s1_sign <= u.a.sign ^ u.b.sign;
			// subnormal operands count as zero
			s1_zero <= (u.a.exp == '0) || (u.b.exp == '0);
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			busy <= 1'b0;
			u.ready <= 1'b1;
			u.valid <= 1'b0;
			u.data <= '0;
		end
		else
		begin
			busy <= accept;
			u.valid <= busy;
			if (busy)
				u.data <= bf16_pack(s1_sign, n_exp, n_man, s1_zero);
			// back up one cycle after the valid pulse
			if (accept)
				u.ready <= 1'b0;
			else if (u.valid)
				u.ready <= 1'b1;
		end
	end

endmodule

//--- hw/bf16_pkg.sv
package bf16_pkg;

	// field widths of the format
	localparam int bf16_exp_w = 8;
	localparam int bf16_man_w = 7;

	// exponent bias
	localparam int bf16_exp_bias = 127;
	// all-ones exponent, encodes infinity
	localparam int bf16_exp_max = 255;

	// sign, biased exponent, stored mantissa without the hidden bit
	typedef struct packed {
		logic sign;
		logic [bf16_exp_w-1:0] exp;
		logic [bf16_man_w-1:0] man;
	} bf16_t;

	// 1.0, the true result of slt
	localparam bf16_t bf16_one = 16'h3f80;

	// command opcodes
	typedef enum logic [1:0] {
		op_add,
		op_sub,
		op_slt,
		op_mul
	} fpu_op_e;

	// final packing step shared by the adder and the multiplier
	// e is the unbiased-plus-bias exponent, may be out of range
	function automatic bf16_t bf16_pack(
		input logic sign,
		input logic signed [9:0] e,
		input logic [bf16_man_w-1:0] man,
		input logic zero
	);
		bf16_t r;
		r.sign = sign;
		r.exp = e[bf16_exp_w-1:0];
		r.man = man;
		// zero and underflow both give +0
		if (zero || e <= 0)
			r = '0;
		// overflow saturates to infinity, sign kept
		else if (e >= bf16_exp_max)
		begin
			r.exp = bf16_exp_w'(bf16_exp_max);
			r.man = '0;
		end
		return r;
	endfunction

endpackage

//--- hw/bf16_slt.sv
module bf16_slt (
	input logic clk,
	input logic arst_n,
	bf16_unit_if.unit u
);
	import bf16_pkg::*;

	logic accept;
	logic zero_a;
	logic zero_b;
	logic neg_a;
	logic neg_b;
	logic [14:0] mag_a;
	logic [14:0] mag_b;
	logic lt;

	assign accept = u.start && u.ready;

	always_comb
	begin
		// subnormals and -0 collapse to +0
		zero_a = (u.a.exp == '0);
		zero_b = (u.b.exp == '0);
		mag_a = zero_a ? '0 : {u.a.exp, u.a.man};
		mag_b = zero_b ? '0 : {u.b.exp, u.b.man};
		neg_a = !zero_a && u.a.sign;
		neg_b = !zero_b && u.b.sign;
		// mixed signs settle it, else compare magnitudes
		if (neg_a != neg_b)
			lt = neg_a;
		else if (neg_a)
			lt = mag_a > mag_b;
		else
			lt = mag_a < mag_b;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			u.ready <= 1'b1;
			u.valid <= 1'b0;
			u.data <= '0;
		end
		else
		begin
			u.valid <= accept;
			if (accept)
			begin
				u.data <= lt ? bf16_one : bf16_t'(0);
				u.ready <= 1'b0;
			end
			else if (u.valid)
				u.ready <= 1'b1;
		end
	end

endmodule

//--- hw/bf16_unit_if.sv
interface bf16_unit_if;
	import bf16_pkg::*;

	// command, from the dispatcher
	logic start;
	bf16_t a;
	bf16_t b;

	// status and result, from the unit
	logic ready;
	logic valid;
	bf16_t data;

	// dispatcher side
	modport disp (
		output start, a, b,
		input ready, valid, data
	);

	// execution unit side
	modport unit (
		input start, a, b,
		output ready, valid, data
	);

endinterface

//--- vlog.f
+incdir+bench
hw/bf16_pkg.sv
hw/bf16_unit_if.sv
hw/bf16_add.sv
hw/bf16_mul.sv
hw/bf16_slt.sv
hw/bf16_fpu.sv
bench/tb_fpu.sv
